// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_atari_cart
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
hdl/atari_bus_pkg.sv
hdl/atari_load_pkg.sv
hdl/cycle_timer.sv
hdl/load_regs.sv
hdl/bank_switcher.sv
hdl/bus_decoder.sv
hdl/console_memory.sv
hdl/atari_cart_top.sv
tests/atari_cart_assert.sv
tests/tb_atari_cart.sv

// ==== hdl/atari_bus_pkg.sv ====
`default_nettype none

package atari_bus_pkg;

  // ====================================================================
  // Cycle timing
  // ====================================================================
  localparam int CYC_W = 4;                              // 16 clocks per CPU cycle

  localparam logic [CYC_W-1:0] CPU_EN_CNT     = 4'd0;    // CPU step
  localparam logic [CYC_W-1:0] TIA_EN_FIRST   = 4'd5;
  localparam logic [CYC_W-1:0] TIA_EN_LAST    = 4'd7;
  localparam logic [CYC_W-1:0] BUS_SAMPLE_CNT = 4'd15;   // Address settled, hotspot check

  // ====================================================================
  // 6502 bus and memory sizes
  // ====================================================================
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;
  localparam int ROM_AW = 15;   // 32 KiB cartridge ROM
  localparam int RAM_AW = 7;    // 128 bytes, RIOT and cart RAM alike
  localparam int BANK_W = 3;    // Up to 8 banks of 4K

  // Hotspots live in the 13-bit cartridge window
  localparam int HOT_AW = 13;

  localparam logic [HOT_AW-1:0] F8_HOT_LO = 13'h1FF8;
  localparam logic [HOT_AW-1:0] F6_HOT_LO = 13'h1FF6;
  localparam logic [HOT_AW-1:0] F4_HOT_LO = 13'h1FF4;

  localparam logic [BANK_W:0] F8_HOT_N = 4'd2;   // Hotspot counts per scheme
  localparam logic [BANK_W:0] F6_HOT_N = 4'd4;
  localparam logic [BANK_W:0] F4_HOT_N = 4'd8;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              rnw;    // High on read
    logic [DATA_W-1:0] dout;   // CPU write data
  } cpu_bus_t;

  typedef struct packed {
    logic tia;
    logic pia;
    logic ram;
    logic cart_ram;
    logic rom;
  } chip_sel_t;

endpackage

`default_nettype wire

// ==== hdl/atari_cart_top.sv ====
`default_nettype none

module atari_cart_top
  import atari_bus_pkg::*;
  import atari_load_pkg::*;
(
  input  wire               clk_sys,
  input  wire               pwr_up_reset_i,
  input  wire cpu_bus_t     cpu_bus_i,
  input  wire [DATA_W-1:0]  tia_dat_i,
  input  wire [DATA_W-1:0]  pia_dat_i,
  input  wire host_wr_t     host_i,
  output logic [DATA_W-1:0] cpu_din_o,
  output logic              cpu_enable_o,
  output logic              tia_enable_o,
  output logic              tia_cs_o,
  output logic              pia_cs_o,
  output logic              cpu_rdy_o,
  output logic              cpu_reset_o
);

  logic              bus_sample;
  ctrl_t             ctrl;
  bank_scheme_e      scheme;
  rom_wr_t           rom_wr;
  chip_sel_t         sel;
  logic [ROM_AW-1:0] rom_addr;
  logic [DATA_W-1:0] ram_dat;
  logic [DATA_W-1:0] cart_ram_dat;
  logic [DATA_W-1:0] rom_dat;

  // ====================================================================
  // Reset, ready and external selects
  // ====================================================================
  assign cpu_reset_o = pwr_up_reset_i || ctrl.cpu_reset;   // Host can hold CPU in reset
  assign cpu_rdy_o   = !ctrl.load_hold;
  assign tia_cs_o    = sel.tia;
  assign pia_cs_o    = sel.pia;

  cycle_timer u_cycle_timer (
    .clk_sys      (clk_sys),
    .rst_i        (pwr_up_reset_i),
    .cpu_enable_o (cpu_enable_o),
    .tia_enable_o (tia_enable_o),
    .bus_sample_o (bus_sample)
  );

  load_regs u_load_regs (
    .clk_sys  (clk_sys),
    .rst_i    (pwr_up_reset_i),   // Not the CPU reset, ctrl would clear itself
    .host_i   (host_i),
    .ctrl_o   (ctrl),
    .scheme_o (scheme),
    .rom_wr_o (rom_wr)
  );

  bank_switcher u_bank_switcher (
    .clk_sys      (clk_sys),
    .rst_i        (cpu_reset_o),
    .bus_sample_i (bus_sample),
    .scheme_i     (scheme),
    .cpu_addr_i   (cpu_bus_i.addr),
    .rom_addr_o   (rom_addr)
  );

  bus_decoder u_bus_decoder (
    .clk_sys        (clk_sys),
    .cpu_addr_i     (cpu_bus_i.addr),
    .cart_ram_en_i  (ctrl.cart_ram_en),
    .tia_dat_i      (tia_dat_i),
    .pia_dat_i      (pia_dat_i),
    .ram_dat_i      (ram_dat),
    .cart_ram_dat_i (cart_ram_dat),
    .rom_dat_i      (rom_dat),
    .sel_o          (sel),
    .cpu_din_o      (cpu_din_o)
  );

  console_memory u_console_memory (
    .clk_sys        (clk_sys),
    .bus_i          (cpu_bus_i),
    .sel_i          (sel),
    .cpu_rdy_i      (cpu_rdy_o),
    .rom_addr_i     (rom_addr),
    .rom_wr_i       (rom_wr),
    .ram_dat_o      (ram_dat),
    .cart_ram_dat_o (cart_ram_dat),
    .rom_dat_o      (rom_dat)
  );

endmodule

`default_nettype wire

// ==== hdl/atari_load_pkg.sv ====
`default_nettype none

package atari_load_pkg;

  import atari_bus_pkg::*;

  // ====================================================================
  // Host loader
  // ====================================================================
  localparam int HOST_AW = 32;

  localparam logic [7:0] SPACE_ROM  = 8'h00;   // Top address byte selects target
  localparam logic [7:0] SPACE_CTRL = 8'hFF;

  typedef struct packed {
    logic               wr;     // One-clock strobe per byte
    logic [HOST_AW-1:0] addr;
    logic [DATA_W-1:0]  data;
  } host_wr_t;

  // Control register, bit 0 at the bottom
  typedef struct packed {
    logic [4:0] spare;
    logic       cart_ram_en;
    logic       load_hold;    // Stalls CPU while loading
    logic       cpu_reset;
  } ctrl_t;

  typedef struct packed {
    logic              we;
    logic [ROM_AW-1:0] addr;
    logic [DATA_W-1:0] data;
  } rom_wr_t;

  // ROM size word, one bit per 4K boundary crossed
  localparam int SIZE_W = 3;

  localparam logic [SIZE_W-1:0] SIZE_8K  = 3'b001;
  localparam logic [SIZE_W-1:0] SIZE_16K = 3'b011;
  localparam logic [SIZE_W-1:0] SIZE_32K = 3'b111;

  typedef enum logic [1:0] {
    NONE,
    F8,
    F6,
    F4
  } bank_scheme_e;

endpackage

`default_nettype wire

// ==== hdl/bank_switcher.sv ====
`default_nettype none

module bank_switcher
  import atari_bus_pkg::*;
  import atari_load_pkg::*;
(
  input  wire               clk_sys,
  input  wire               rst_i,          // CPU reset
  input  wire               bus_sample_i,
  input  wire bank_scheme_e scheme_i,
  input  wire [ADDR_W-1:0]  cpu_addr_i,
  output logic [ROM_AW-1:0] rom_addr_o
);

  logic [HOT_AW-1:0] hot_base;
  logic [BANK_W:0]   hot_span;   // Number of hotspots, 0 when none
  logic [HOT_AW-1:0] hot_off;
  logic              hot_hit;
  logic [BANK_W-1:0] bank_q;

  // ====================================================================
  // Hotspot window of the active scheme
  // ====================================================================
  always_comb begin
    case (scheme_i)
      F8: begin
        hot_base = F8_HOT_LO;
        hot_span = F8_HOT_N;
      end
      F6: begin
        hot_base = F6_HOT_LO;
        hot_span = F6_HOT_N;
      end
      F4: begin
        hot_base = F4_HOT_LO;
        hot_span = F4_HOT_N;
      end
      default: begin
        hot_base = '0;
        hot_span = '0;           // Empty window, bank never moves
      end
    endcase
  end

  // Offset into the window doubles as the bank number
  assign hot_off = cpu_addr_i[HOT_AW-1:0] - hot_base;
  assign hot_hit = (hot_off < HOT_AW'(hot_span));   // Below base wraps high

  // ====================================================================
  // Bank register
  // ====================================================================
  always_ff @(posedge clk_sys) begin
    if (rst_i)
      bank_q <= '0;
    else if (bus_sample_i && hot_hit)
      bank_q <= hot_off[BANK_W-1:0];   // Sampled once per CPU cycle
  end

  // 4K window of the selected bank
  assign rom_addr_o = {bank_q, cpu_addr_i[11:0]};

endmodule

`default_nettype wire

// ==== hdl/bus_decoder.sv ====
`default_nettype none

module bus_decoder
  import atari_bus_pkg::*;
(
  input  wire               clk_sys,
  input  wire [ADDR_W-1:0]  cpu_addr_i,
  input  wire               cart_ram_en_i,
  input  wire [DATA_W-1:0]  tia_dat_i,
  input  wire [DATA_W-1:0]  pia_dat_i,
  input  wire [DATA_W-1:0]  ram_dat_i,
  input  wire [DATA_W-1:0]  cart_ram_dat_i,
  input  wire [DATA_W-1:0]  rom_dat_i,
  output chip_sel_t         sel_o,
  output logic [DATA_W-1:0] cpu_din_o
);

  // ====================================================================
  // Chip selects, partial decode as on the console
  // ====================================================================
  always_comb begin
    sel_o          = '0;
    sel_o.tia      = !cpu_addr_i[12] && !cpu_addr_i[7];
    sel_o.ram      = !cpu_addr_i[12] && !cpu_addr_i[9] && cpu_addr_i[7];
    sel_o.pia      = !cpu_addr_i[12] &&  cpu_addr_i[9] && cpu_addr_i[7];
    sel_o.cart_ram = cart_ram_en_i && cpu_addr_i[12] &&
                     (cpu_addr_i[11:8] == 4'h0);   // First page of cart space
    sel_o.rom      = cpu_addr_i[12];
  end

  // ====================================================================
  // Read data mux
  // ====================================================================
  // Cart RAM wins over ROM inside its page
  always_ff @(posedge clk_sys) begin
    if (sel_o.tia)
      cpu_din_o <= tia_dat_i;
    else if (sel_o.pia)
      cpu_din_o <= pia_dat_i;
    else if (sel_o.ram)
      cpu_din_o <= ram_dat_i;
    else if (sel_o.cart_ram)
      cpu_din_o <= cart_ram_dat_i;
    else if (sel_o.rom)
      cpu_din_o <= rom_dat_i;
    else
      cpu_din_o <= '0;
  end

endmodule

`default_nettype wire

// ==== hdl/console_memory.sv ====
`default_nettype none

module console_memory
  import atari_bus_pkg::*;
  import atari_load_pkg::*;
(
  input  wire               clk_sys,
  input  wire cpu_bus_t     bus_i,
  input  wire chip_sel_t    sel_i,
  input  wire               cpu_rdy_i,
  input  wire [ROM_AW-1:0]  rom_addr_i,
  input  wire rom_wr_t      rom_wr_i,
  output logic [DATA_W-1:0] ram_dat_o,
  output logic [DATA_W-1:0] cart_ram_dat_o,
  output logic [DATA_W-1:0] rom_dat_o
);

  logic [DATA_W-1:0] rom_mem [2**ROM_AW];
  logic [1:0]        ram_we;   // [0] RIOT RAM, [1] cart RAM

  // ====================================================================
  // Cartridge ROM
  // ====================================================================
  always_ff @(posedge clk_sys) begin
    if (rom_wr_i.we)
      rom_mem[rom_wr_i.addr] <= rom_wr_i.data;   // Host loader port
    rom_dat_o <= rom_mem[rom_addr_i];            // CPU read port
  end

  // ====================================================================
  // RIOT RAM and cartridge RAM
  // ====================================================================
  // CPU writes only, and not while stalled
  assign ram_we[0] = !bus_i.rnw && sel_i.ram && cpu_rdy_i;
  assign ram_we[1] = !bus_i.rnw && sel_i.cart_ram && cpu_rdy_i;

  for (genvar g = 0; g < 2; g++) begin : g_ram
    logic [DATA_W-1:0] mem [2**RAM_AW];
    logic [DATA_W-1:0] rd_q;

    always_ff @(posedge clk_sys) begin
      if (ram_we[g])
        mem[bus_i.addr[RAM_AW-1:0]] <= bus_i.dout;
      rd_q <= mem[bus_i.addr[RAM_AW-1:0]];   // Old data on a write cycle
    end
  end

  assign ram_dat_o      = g_ram[0].rd_q;
  assign cart_ram_dat_o = g_ram[1].rd_q;

endmodule

`default_nettype wire

// ==== hdl/cycle_timer.sv ====
`default_nettype none

module cycle_timer
  import atari_bus_pkg::*;
(
  input  wire  clk_sys,
  input  wire  rst_i,
  output logic cpu_enable_o,
  output logic tia_enable_o,
  output logic bus_sample_o
);

  logic [CYC_W-1:0] cyc_cnt;
  logic [CYC_W-1:0] cyc_nxt;

  assign cyc_nxt = cyc_cnt + 1'b1;   // Free running, wraps at 16

  // ====================================================================
  // Enables decoded from the next count
  // ====================================================================
  // Registered decode lines each enable up with its own count value
  always_ff @(posedge clk_sys) begin
    if (rst_i) begin
      cyc_cnt      <= '0;
      cpu_enable_o <= 1'b0;
      tia_enable_o <= 1'b0;
      bus_sample_o <= 1'b0;
    end else begin
      cyc_cnt      <= cyc_nxt;
      cpu_enable_o <= (cyc_nxt == CPU_EN_CNT);        // Count 0
      tia_enable_o <= (cyc_nxt >= TIA_EN_FIRST) &&
                      (cyc_nxt <= TIA_EN_LAST);       // Counts 5 to 7
      bus_sample_o <= (cyc_nxt == BUS_SAMPLE_CNT);    // Last count of cycle
    end
  end

endmodule

`default_nettype wire

// ==== hdl/load_regs.sv ====
`default_nettype none

module load_regs
  import atari_bus_pkg::*;
  import atari_load_pkg::*;
(
  input  wire           clk_sys,
  input  wire           rst_i,
  input  wire host_wr_t host_i,
  output ctrl_t         ctrl_o,
  output bank_scheme_e  scheme_o,
  output rom_wr_t       rom_wr_o
);

  logic              host_ctrl_wr;
  logic              host_rom_wr;
  ctrl_t             ctrl_q;
  logic              rom_we_q;
  logic [ROM_AW-1:0] rom_addr_q;
  logic [DATA_W-1:0] rom_data_q;
  logic [SIZE_W-1:0] rom_size_q;
  logic [SIZE_W-1:0] size_nxt;

  // Split by address space
  assign host_ctrl_wr = host_i.wr && (host_i.addr[HOST_AW-1 -: 8] == SPACE_CTRL);
  assign host_rom_wr  = host_i.wr && (host_i.addr[HOST_AW-1 -: 8] == SPACE_ROM);

  // ====================================================================
  // Control register and ROM write port
  // ====================================================================
  always_ff @(posedge clk_sys) begin
    if (rst_i) begin
      ctrl_q   <= '0;    // Hold and CPU reset released
      rom_we_q <= 1'b0;
    end else begin
      rom_we_q <= host_rom_wr;
      if (host_ctrl_wr)
        ctrl_q <= host_i.data;
    end
  end

  // Address and data just follow the strobe
  always_ff @(posedge clk_sys) begin
    rom_addr_q <= host_i.addr[ROM_AW-1:0];
    rom_data_q <= host_i.data;
  end

  // ====================================================================
  // ROM size tracking
  // ====================================================================
  always_comb begin
    size_nxt = rom_size_q;
    if (host_i.addr[13:0] == '0)
      size_nxt = '0;                 // Fresh image starts at 0
    if (host_i.addr[12])
      size_nxt[0] = 1'b1;            // Past 4K
    if (host_i.addr[13])
      size_nxt[1] = 1'b1;            // Past 8K
    if (host_i.addr[14])
      size_nxt[2] = 1'b1;            // Past 16K
  end

  always_ff @(posedge clk_sys) begin
    if (host_rom_wr)
      rom_size_q <= size_nxt;
  end

  // Size word to scheme
  always_comb begin
    case (rom_size_q)
      SIZE_8K:  scheme_o = F8;
      SIZE_16K: scheme_o = F6;
      SIZE_32K: scheme_o = F4;
      default:  scheme_o = NONE;   // 2K or 4K, no banking
    endcase
  end

  assign ctrl_o   = ctrl_q;
  assign rom_wr_o = '{we: rom_we_q, addr: rom_addr_q, data: rom_data_q};

endmodule

`default_nettype wire

// ==== tests/atari_cart_assert.sv ====
`default_nettype none

module atari_cart_assert
  import atari_bus_pkg::*;
  import atari_load_pkg::*;
(
  input wire            clk_sys,
  input wire            rst_i,
  input wire chip_sel_t sel_i,
  input wire            cpu_enable_i,
  input wire            tia_enable_i,
  input wire host_wr_t  host_i,
  input wire            cpu_rdy_i
);

  timeunit 1ns;
  timeprecision 1ps;

  ctrl_t wr_ctrl;
  logic  hold_wr;

  // Control write that raises load_hold
  assign wr_ctrl = host_i.data;
  assign hold_wr = host_i.wr && (host_i.addr[HOST_AW-1 -: 8] == SPACE_CTRL) &&
                   wr_ctrl.load_hold;

  // ====================================================================
  // Properties
  // ====================================================================
  a_sel_onehot : assert property (@(posedge clk_sys) disable iff (rst_i)
    $onehot0({sel_i.tia, sel_i.pia, sel_i.ram}))
    else $error("More than one of TIA, PIA and RIOT RAM selected");

  a_enable_excl : assert property (@(posedge clk_sys) disable iff (rst_i)
    !(cpu_enable_i && tia_enable_i))
    else $error("cpu_enable and tia_enable high together");

  a_hold_stall : assert property (@(posedge clk_sys) disable iff (rst_i)
    hold_wr |=> !cpu_rdy_i)
    else $error("cpu_rdy_o still high after load_hold write");

endmodule

bind atari_cart_top atari_cart_assert u_atari_cart_assert (
  .clk_sys      (clk_sys),
  .rst_i        (pwr_up_reset_i),
  .sel_i        (sel),
  .cpu_enable_i (cpu_enable_o),
  .tia_enable_i (tia_enable_o),
  .host_i       (host_i),
  .cpu_rdy_i    (cpu_rdy_o)
);

`default_nettype wire

// ==== tests/tb_atari_cart.sv ====
`default_nettype none

module tb_atari_cart
  import atari_bus_pkg::*;
  import atari_load_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 64;   // Clocks, four CPU cycles

  logic              clk_sys = 1'b0;
  logic              pwr_up_reset_i;
  cpu_bus_t          cpu_bus_i;
  logic [DATA_W-1:0] tia_dat_i;
  logic [DATA_W-1:0] pia_dat_i;
  host_wr_t          host_i;
  logic [DATA_W-1:0] cpu_din_o;
  logic              cpu_enable_o;
  logic              tia_enable_o;
  logic              tia_cs_o;
  logic              pia_cs_o;
  logic              cpu_rdy_o;
  logic              cpu_reset_o;

  int                err_cnt = 0;
  int                chk_cnt = 0;
  logic [DATA_W-1:0] riot_model [2**RAM_AW];   // Expected RIOT RAM contents
  logic [BANK_W-1:0] cur_bank;                 // Bank the DUT should be on

  always #20 clk_sys = ~clk_sys;   // 40 ns period

  atari_cart_top u_atari_cart_top (
    .clk_sys        (clk_sys),
    .pwr_up_reset_i (pwr_up_reset_i),
    .cpu_bus_i      (cpu_bus_i),
    .tia_dat_i      (tia_dat_i),
    .pia_dat_i      (pia_dat_i),
    .host_i         (host_i),
    .cpu_din_o      (cpu_din_o),
    .cpu_enable_o   (cpu_enable_o),
    .tia_enable_o   (tia_enable_o),
    .tia_cs_o       (tia_cs_o),
    .pia_cs_o       (pia_cs_o),
    .cpu_rdy_o      (cpu_rdy_o),
    .cpu_reset_o    (cpu_reset_o)
  );

  // ====================================================================
  // Reference model and checks
  // ====================================================================
  // Image byte folds all 15 address bits so each bank reads differently
  function automatic logic [DATA_W-1:0] img_byte(input logic [ROM_AW-1:0] a);
    return a[7:0] ^ {1'b0, a[14:8]} ^ 8'h5A;
  endfunction

  task automatic abort_run(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic check_byte(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_sel(input chip_sel_t got, input chip_sel_t exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    chk_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // ====================================================================
  // Bus and host drivers
  // ====================================================================
  task automatic wait_cpu_enable();
    int n;
    n = 0;
    do begin
      @(posedge clk_sys);
      n++;
    end while (!cpu_enable_o && n < WAIT_LIMIT);
    if (!cpu_enable_o)
      abort_run("no cpu_enable_o pulse");
  endtask

  task automatic read_byte(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
    wait_cpu_enable();
    cpu_bus_i <= '{addr: a, rnw: 1'b1, dout: '0};
    repeat (3) @(posedge clk_sys);   // Memory, then mux register
    d = cpu_din_o;
  endtask

  task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    wait_cpu_enable();
    cpu_bus_i <= '{addr: a, rnw: 1'b0, dout: d};
    @(posedge clk_sys);              // Single write edge
    cpu_bus_i.rnw <= 1'b1;
  endtask

  // Hold a hotspot across the next bus sample
  task automatic hit_hotspot(input logic [ADDR_W-1:0] a);
    wait_cpu_enable();
    cpu_bus_i <= '{addr: a, rnw: 1'b1, dout: '0};
    @(posedge clk_sys);
    wait_cpu_enable();               // Sample fired the clock before
  endtask

  task automatic host_write(input logic [HOST_AW-1:0] a, input logic [DATA_W-1:0] d);
    @(posedge clk_sys);
    host_i <= '{wr: 1'b1, addr: a, data: d};
    @(posedge clk_sys);
    host_i.wr <= 1'b0;
  endtask

  task automatic set_ctrl(input ctrl_t c);
    host_write({SPACE_CTRL, 24'h0}, c);
    @(posedge clk_sys);              // Register now visible at the outputs
  endtask

  // Back to back strobes, one byte per clock
  task automatic load_image(input int nbytes);
    int a;
    for (a = 0; a < nbytes; a++) begin
      @(posedge clk_sys);
      host_i <= '{wr: 1'b1, addr: {SPACE_ROM, 24'(a)}, data: img_byte(ROM_AW'(a))};
    end
    @(posedge clk_sys);
    host_i.wr <= 1'b0;
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic test_enables();
    int gap;
    int p;
    wait_cpu_enable();
    for (p = 0; p < 3; p++) begin
      gap = 0;
      do begin
        @(posedge clk_sys);
        gap++;
        check_bit(tia_enable_o, (gap >= 5 && gap <= 7), "tia_enable_o window");
      end while (!cpu_enable_o && gap < WAIT_LIMIT);
      check_count(gap, 16, "cpu_enable_o period");
    end
  endtask

  task automatic test_selects();
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    chip_sel_t         got;
    chip_sel_t         exp;
    int                i;
    for (i = 0; i < 24; i++) begin
      a       = ADDR_W'($urandom);
      a[12]   = 1'b0;                // Console side only
      exp     = '0;
      exp.tia = !a[7];
      exp.pia = a[9] && a[7];
      tia_dat_i <= DATA_W'($urandom);
      pia_dat_i <= DATA_W'($urandom);
      read_byte(a, d);
      got     = '0;
      got.tia = tia_cs_o;
      got.pia = pia_cs_o;
      check_sel(got, exp, "TIA and PIA selects");
      if (exp.tia)
        check_byte(d, tia_dat_i, "TIA read data");
      else if (exp.pia)
        check_byte(d, pia_dat_i, "PIA read data");
    end
  endtask

  task automatic test_riot_ram();
    logic [DATA_W-1:0] d;
    ctrl_t             c;
    int                i;
    for (i = 0; i < 2**RAM_AW; i++) begin
      riot_model[i] = DATA_W'($urandom);
      write_byte(ADDR_W'(16'h0080 + i), riot_model[i]);
    end
    for (i = 0; i < 2**RAM_AW; i++) begin
      read_byte(ADDR_W'(16'h0080 + i), d);
      check_byte(d, riot_model[i], "RIOT RAM readback");
    end
    c           = '0;
    c.load_hold = 1'b1;
    set_ctrl(c);
    check_bit(cpu_rdy_o, 1'b0, "cpu_rdy_o during load_hold");
    for (i = 0; i < 8; i++)
      write_byte(ADDR_W'(16'h0080 + i * 16), ~riot_model[i * 16]);   // Must be dropped
    set_ctrl('0);
    check_bit(cpu_rdy_o, 1'b1, "cpu_rdy_o after load_hold");
    for (i = 0; i < 8; i++) begin
      read_byte(ADDR_W'(16'h0080 + i * 16), d);
      check_byte(d, riot_model[i * 16], "RIOT RAM held write");
    end
  endtask

  task automatic test_f8();
    logic [DATA_W-1:0] d;
    ctrl_t             c;
    c           = '0;
    c.load_hold = 1'b1;
    set_ctrl(c);
    load_image(8192);
    set_ctrl('0);
    read_byte(16'h1000, d);
    check_byte(d, img_byte(15'h0000), "F8 bank 0 at 1000");
    hit_hotspot(16'h1FF9);
    read_byte(16'h1000, d);
    check_byte(d, img_byte(15'h1000), "F8 bank 1 at 1000");
    read_byte(16'h1ABC, d);
    check_byte(d, img_byte(15'h1ABC), "F8 bank 1 at 1ABC");
    cur_bank = 3'd1;
  endtask

  task automatic test_f4();
    logic [DATA_W-1:0] d;
    logic [11:0]       off;
    ctrl_t             c;
    int                b;
    c           = '0;
    c.load_hold = 1'b1;
    set_ctrl(c);
    load_image(32768);
    set_ctrl('0);
    for (b = 0; b < 8; b++) begin
      hit_hotspot(ADDR_W'(32'h1FF4 + b));
      off = 12'($urandom % 32'hF00);   // Stay below the hotspots
      read_byte({4'h1, off}, d);
      check_byte(d, img_byte({3'(b), off}), "F4 bank read");
    end
    cur_bank = 3'd7;
  endtask

  task automatic test_cart_ram();
    logic [DATA_W-1:0] d;
    logic [DATA_W-1:0] wdat;
    ctrl_t             c;
    c             = '0;
    c.cart_ram_en = 1'b1;
    set_ctrl(c);
    wdat = DATA_W'($urandom);
    write_byte(16'h1000, wdat);
    read_byte(16'h1000, d);
    check_byte(d, wdat, "cart RAM readback");
    set_ctrl('0);
    read_byte(16'h1000, d);
    check_byte(d, img_byte({cur_bank, 12'h000}), "ROM under cart RAM page");
    c           = '0;
    c.cpu_reset = 1'b1;
    set_ctrl(c);
    check_bit(cpu_reset_o, 1'b1, "cpu_reset_o from control");
    set_ctrl('0);
    check_bit(cpu_reset_o, 1'b0, "cpu_reset_o released");
    cur_bank = '0;
    read_byte(16'h1000, d);
    check_byte(d, img_byte(15'h0000), "bank 0 after CPU reset");
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    void'($urandom(32'h5853));
    pwr_up_reset_i <= 1'b1;
    cpu_bus_i      <= '{addr: '0, rnw: 1'b1, dout: '0};
    tia_dat_i      <= '0;
    pia_dat_i      <= '0;
    host_i         <= '0;
    cur_bank = '0;
    repeat (8) @(posedge clk_sys);
    pwr_up_reset_i <= 1'b0;

    test_enables();
    test_selects();
    test_riot_ram();
    test_f8();
    test_f4();
    test_cart_ram();

    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
